/* filelist.f */
+incdir+include
source/vit_mlp_pkg.sv
source/fc1_gelu_stage.sv
source/act_buffer.sv
source/fc2_stage.sv
source/mlp_vit.sv
sim/tb_clock_gen.sv
sim/mlp_vit_assert.sv
sim/tb_mlp_vit.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the ViT MLP testbench with Verilator.
# The result is decided by the pass line in sim.log.
set -e
cd "$(dirname "$0")"

verilator --binary --assert -j 0 --top-module tb_mlp_vit -f filelist.f -o sim_mlp_vit

# tee keeps the pipeline status at zero, so a failing run reaches the grep
./obj_dir/sim_mlp_vit | tee sim.log

if grep -qx "Finished with no errors" sim.log; then
    echo "PASS"
    exit 0
fi
echo "FAIL"
exit 1

/* sim/tb_mlp_vit.sv */
//--------------------------------------
// Directed testbench for the ViT MLP
// Loads weights through wload, runs
// patches and checks y against a Q8.8
// reference model of both layers
//--------------------------------------
`timescale 1ns/100ps
`include "vit_mlp_consts.svh"

module tb_mlp_vit import vit_mlp_pkg::*; ();

    localparam int HID       = `VIT_HIDDEN_DIM;
    localparam int MLP       = `VIT_MLP_DIM;
    localparam int Q_ONE     = 1 << `VIT_TRUNC_LSB;   // 1.0 in Q8.8
    localparam int NUM_TESTS = 5;

    logic     clk, por_rst, soft_rst, rst;
    logic     start, valid_in, valid_out, done;
    hid_vec_t x, y;
    wload_t   wload;

    // Model copy of what sits in the layers
    q88_u        w1_m [MLP*HID];
    q88_u        b1_m [MLP];
    q88_u        w2_m [HID*MLP];
    q88_u        b2_m [HID];
    logic [31:0] lcg_state;
    int          errors;

    assign rst = por_rst | soft_rst;   // Power-on or mid-test reset

    tb_clock_gen u_clk (.clk(clk), .rst(por_rst));

    mlp_vit dut0 (
        .clk       (clk),
        .rst       (rst),
        .start     (start),
        .valid_in  (valid_in),
        .x         (x),
        .wload     (wload),
        .y         (y),
        .valid_out (valid_out),
        .done      (done)
    );

    //--------------------------------------
    // Stimulus helpers and reference model
    //--------------------------------------
    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    function automatic q88_u q88_of(input int v);
        q88_u r;
        r.raw = 16'(v);
        return r;
    endfunction

    // Magnitude under 4.0
    function automatic q88_u rand_q88();
        return q88_of(int'(lcg_next() >> 8) % 2047 - 1023);
    endfunction

    function automatic hid_vec_t vec_of(input int a, input int b, input int c, input int d);
        hid_vec_t v;
        v[0] = q88_of(a);
        v[1] = q88_of(b);
        v[2] = q88_of(c);
        v[3] = q88_of(d);
        return v;
    endfunction

    function automatic hid_vec_t rand_vec();
        hid_vec_t v;
        for (int i = 0; i < HID; i++)
            v[i] = rand_q88();
        return v;
    endfunction

    // Integer part below -2 means value below -2.0
    function automatic q88_u gelu_ref(input q88_u v);
        int vi;
        vi = int'(v.raw);
        if (vi < -(`VIT_GELU_LIMIT * Q_ONE))
            return q88_of(0);
        else if (vi >= `VIT_GELU_LIMIT * Q_ONE)
            return v;
        return q88_of((vi >>> 1) + Q_ONE / 2);         // Half plus 0.5
    endfunction

    function automatic hid_vec_t ref_mlp(input hid_vec_t xv);
        q88_u               h [MLP];
        hid_vec_t           yv;
        logic signed [31:0] acc;
        for (int n = 0; n < MLP; n++) begin
            acc = '0;
            for (int i = 0; i < HID; i++)
                acc = acc + int'(xv[i].raw) * int'(w1_m[n*HID+i].raw);
            h[n].raw = acc[`VIT_TRUNC_LSB +: `VIT_DATA_W] + b1_m[n].raw;   // 16-bit wrap
            h[n]     = gelu_ref(h[n]);
        end
        for (int o = 0; o < HID; o++) begin
            acc = '0;
            for (int k = 0; k < MLP; k++)
                acc = acc + int'(h[k].raw) * int'(w2_m[o*MLP+k].raw);
            yv[o].raw = acc[`VIT_TRUNC_LSB +: `VIT_DATA_W] + b2_m[o].raw;
        end
        return yv;
    endfunction

    //--------------------------------------
    // Checks
    //--------------------------------------
    task automatic fail_run(input string msg);
        errors++;
        $display("%s", msg);
        $display("Finished with errors");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_vec(input string name, input hid_vec_t exp, input hid_vec_t act);
        if (act !== exp)
            fail_run($sformatf("mismatch %s: expected %h, actual %h", name, exp, act));
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp)
            fail_run($sformatf("mismatch %s: expected %b, actual %b", name, exp, act));
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (act != exp)
            fail_run($sformatf("mismatch %s: expected %0d, actual %0d", name, exp, act));
    endtask

    //--------------------------------------
    // Bus drivers
    //--------------------------------------
    task automatic write_word(input logic layer, input logic is_bias, input int addr,
                              input q88_u data);
        @(negedge clk);
        wload.en      = 1'b1;
        wload.layer   = layer;
        wload.is_bias = is_bias;
        wload.addr    = 5'(addr);
        wload.data    = data;
    endtask

    task automatic load_fc1();
        for (int i = 0; i < MLP*HID; i++)
            write_word(1'b0, 1'b0, i, w1_m[i]);
        for (int n = 0; n < MLP; n++)
            write_word(1'b0, 1'b1, n, b1_m[n]);
        @(negedge clk);
        wload.en = 1'b0;
    endtask

    task automatic load_fc2();
        for (int i = 0; i < HID*MLP; i++)
            write_word(1'b1, 1'b0, i, w2_m[i]);
        for (int o = 0; o < HID; o++)
            write_word(1'b1, 1'b1, o, b2_m[o]);
        @(negedge clk);
        wload.en = 1'b0;
    endtask

    // One accepted patch plus extra starts while fc1 and fc2 are busy when poke is set
    task automatic run_and_check(input string name, input hid_vec_t xv, input logic poke);
        int cyc;
        @(negedge clk);
        x        = xv;
        start    = 1'b1;
        valid_in = 1'b1;
        cyc      = 0;
        do begin
            @(negedge clk);
            cyc++;
            start    = poke && (cyc == 10 || cyc == 45);
            valid_in = start;
            x        = start ? hid_vec_t'(~xv) : xv;
            if (cyc > `VIT_LATENCY + 40)
                fail_run($sformatf("timeout in %s, done never arrived", name));
        end while (!done);
        check_count({name, " latency"}, `VIT_LATENCY, cyc);
        check_bit({name, " valid_out"}, 1'b1, valid_out);
        check_vec(name, ref_mlp(xv), y);
        @(negedge clk);
        check_bit({name, " done width"}, 1'b0, done);
    endtask

    //--------------------------------------
    // Tests
    //--------------------------------------
    task automatic test_gelu_regions();
        for (int n = 0; n < MLP; n++) begin
            for (int i = 0; i < HID; i++)                // Neurons 4..7 see -x
                w1_m[n*HID+i] = q88_of((i == n % HID) ? ((n < HID) ? Q_ONE : -Q_ONE) : 0);
            b1_m[n] = q88_of(0);
        end
        for (int o = 0; o < HID; o++) begin
            for (int k = 0; k < MLP; k++)                // y[o] = h[o] + h[o+4]
                w2_m[o*MLP+k] = q88_of((k == o || k == o + HID) ? Q_ONE : 0);
            b2_m[o] = q88_of(0);
        end
        load_fc1();
        load_fc2();
        run_and_check("gelu_edges", vec_of(-512, -513, 512, 128), 1'b0);  // -2, below, 2, 0.5
        run_and_check("gelu_mixed", vec_of(-896, 256, -320, 768), 1'b0);
    endtask

    task automatic test_bias_wrap();
        int b1_raw [MLP] = '{32512, 25600, -768, -512, -384, 0, 256, 640};
        int b2_raw [HID] = '{32512, 512, -32768, -128};
        for (int n = 0; n < MLP; n++) begin
            for (int i = 0; i < HID; i++)
                w1_m[n*HID+i] = q88_of(0);
            b1_m[n] = q88_of(b1_raw[n]);
        end
        for (int o = 0; o < HID; o++) begin
            for (int k = 0; k < MLP; k++)                // Bias add wraps on outputs 0 and 1
                w2_m[o*MLP+k] = q88_of((k == 0 || k == o + 2) ? Q_ONE : 0);
            b2_m[o] = q88_of(b2_raw[o]);
        end
        load_fc1();
        load_fc2();
        run_and_check("bias_wrap", vec_of(300, -700, 50, 900), 1'b0);
    endtask

    task automatic test_random();
        for (int i = 0; i < MLP*HID; i++) begin
            w1_m[i] = rand_q88();
            w2_m[i] = rand_q88();
        end
        for (int n = 0; n < MLP; n++)
            b1_m[n] = rand_q88();
        for (int o = 0; o < HID; o++)
            b2_m[o] = rand_q88();
        load_fc1();
        load_fc2();
        for (int p = 0; p < 3; p++)
            run_and_check($sformatf("random_%0d", p), rand_vec(), 1'b0);
    endtask

    task automatic test_start_gating();
        @(negedge clk);
        x        = rand_vec();
        start    = 1'b1;                                // valid_in stays low
        @(negedge clk);
        start    = 1'b0;
        repeat (`VIT_LATENCY + 2) begin                 // Long enough for a wrong done
            @(negedge clk);
            check_bit("start without valid_in", 1'b0, done);
        end
        run_and_check("start_while_busy", rand_vec(), 1'b1);
        repeat (`VIT_LATENCY) begin
            @(negedge clk);
            check_bit("extra done", 1'b0, done);
        end
    endtask

    task automatic test_reset_reload();
        hid_vec_t xv;
        xv = rand_vec();
        @(negedge clk);
        x        = xv;
        start    = 1'b1;
        valid_in = 1'b1;
        @(negedge clk);
        start    = 1'b0;
        valid_in = 1'b0;
        repeat (`VIT_LATENCY - 1) @(negedge clk);
        check_bit("done before reset", 1'b1, done);
        soft_rst = 1'b1;                                // Hits while done is up
        @(negedge clk);
        check_bit("reset done", 1'b0, done);
        check_bit("reset valid_out", 1'b0, valid_out);
        check_vec("reset y", '0, y);
        soft_rst = 1'b0;
        for (int i = 0; i < HID*MLP; i++)
            w2_m[i] = rand_q88();
        for (int o = 0; o < HID; o++)
            b2_m[o] = rand_q88();
        load_fc2();                                     // fc1 keeps its weights
        run_and_check("fc2_reload", xv, 1'b0);
    endtask

    //--------------------------------------
    // Watchdog and main sequence
    //--------------------------------------
    initial begin : watchdog
        repeat (NUM_TESTS * (`VIT_LATENCY + 200)) @(posedge clk);
        fail_run("watchdog expired before the tests finished");
    end

    initial begin
        lcg_state = 32'd25047;
        errors    = 0;
        soft_rst  = 1'b0;
        start     = 1'b0;
        valid_in  = 1'b0;
        x         = '0;
        wload     = '0;
        wait (por_rst === 1'b0);
        @(negedge clk);
        check_bit("por done", 1'b0, done);
        check_bit("por valid_out", 1'b0, valid_out);
        check_vec("por y", '0, y);
        test_gelu_regions();
        test_bias_wrap();
        test_random();
        test_start_gating();
        test_reset_reload();
        if (errors == 0) begin
            $display("Finished with no errors");
            $finish;
        end else begin
            fail_run("errors were counted before the end of the run");
        end
    end

endmodule

/* sim/mlp_vit_assert.sv */
//--------------------------------------
// Protocol checks for the MLP top level
// Bound into mlp_vit, watches launch,
// the buffer write port and done
//--------------------------------------
`timescale 1ns/100ps
`include "vit_mlp_consts.svh"

module mlp_vit_assert import vit_mlp_pkg::*; (
    input logic    clk,
    input logic    rst,
    input logic    launch,
    input act_wr_t act_wr,
    input logic    full,
    input logic    done,
    input logic    valid_out
);

    logic       pend;       // Launch seen, done still due
    logic [7:0] lat_cnt;    // Edges since launch

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pend    <= 1'b0;
            lat_cnt <= '0;
        end else if (launch) begin
            pend    <= 1'b1;
            lat_cnt <= 8'd1;
        end else if (done) begin
            pend    <= 1'b0;
        end else if (pend) begin
            lat_cnt <= lat_cnt + 8'd1;
        end
    end

    a_done_valid : assert property (@(posedge clk) disable iff (rst) done |-> valid_out)
        else $error("done without valid_out");

    a_done_single : assert property (@(posedge clk) disable iff (rst) done |=> !done)
        else $error("done high for two cycles");

    // Buffer takes no writes once full
    a_no_wr_full : assert property (@(posedge clk) disable iff (rst) act_wr.en |-> !full)
        else $error("activation write while buffer full");

    a_done_on_time : assert property (@(posedge clk) disable iff (rst)
        done |-> (pend && lat_cnt == 8'(`VIT_LATENCY)))
        else $error("done outside the fixed latency");

    a_latency_hit : assert property (@(posedge clk) disable iff (rst)
        (pend && lat_cnt == 8'(`VIT_LATENCY)) |-> done)
        else $error("done missing at the fixed latency");

endmodule

bind mlp_vit mlp_vit_assert u_assert (
    .clk       (clk),
    .rst       (rst),
    .launch    (launch),
    .act_wr    (act_wr),
    .full      (full),
    .done      (done),
    .valid_out (valid_out)
);

/* sim/tb_clock_gen.sv */
//--------------------------------------
// Testbench clock and power-on reset
// 100 ns period, reset held 8 cycles
//--------------------------------------
`timescale 1ns/100ps

module tb_clock_gen (
    output logic clk,
    output logic rst
);

    localparam int HALF_PERIOD = 50;    // ns
    localparam int RST_CYCLES  = 8;

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (RST_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;                     // Release away from the rising edge
    end

endmodule

/* source/mlp_vit.sv */
//--------------------------------------
// ViT encoder MLP, one patch at a time
// start with valid_in launches while
// idle, done with valid_out pulses
// VIT_LATENCY cycles later. Weights go
// in through wload while idle
//--------------------------------------
`timescale 1ns/100ps
`include "vit_mlp_consts.svh"

module mlp_vit import vit_mlp_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     start,
    input  logic     valid_in,
    input  hid_vec_t x,
    input  wload_t   wload,       // Shared by both layers
    output hid_vec_t y,
    output logic     valid_out,
    output logic     done
);

    logic                      launch;
    logic                      fc1_busy;
    logic                      fc2_busy;
    act_wr_t                   act_wr;     // fc1 to buffer
    logic [`VIT_ACT_IDX_W-1:0] rd_idx;     // fc2 read address
    q88_u                      rd_data;
    logic                      full;

    //--------------------------------------
    // Launch gate
    //--------------------------------------
    // Requests while either layer runs are dropped
    assign launch = start && valid_in && !fc1_busy && !fc2_busy;

    fc1_gelu_stage u_fc1 (
        .clk    (clk),
        .rst    (rst),
        .launch (launch),
        .x      (x),
        .wload  (wload),
        .act_wr (act_wr),
        .busy   (fc1_busy)
    );

    // Launch also empties the buffer
    act_buffer u_buf (
        .clk     (clk),
        .rst     (rst),
        .clear   (launch),
        .act_wr  (act_wr),
        .rd_idx  (rd_idx),
        .rd_data (rd_data),
        .full    (full)
    );

    fc2_stage u_fc2 (
        .clk       (clk),
        .rst       (rst),
        .full      (full),
        .rd_data   (rd_data),
        .wload     (wload),
        .rd_idx    (rd_idx),
        .y         (y),
        .done      (done),
        .valid_out (valid_out),
        .busy      (fc2_busy)
    );

endmodule

/* source/fc2_stage.sv */
//--------------------------------------
// Second linear layer. Starts when the
// buffer turns full, runs MLP_DIM MAC
// cycles plus a finish cycle per output
// and commits y with a done pulse
//--------------------------------------
`timescale 1ns/100ps
`include "vit_mlp_consts.svh"

module fc2_stage import vit_mlp_pkg::*; (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      full,
    input  q88_u                      rd_data,
    input  wload_t                    wload,
    output logic [`VIT_ACT_IDX_W-1:0] rd_idx,
    output hid_vec_t                  y,
    output logic                      done,
    output logic                      valid_out,
    output logic                      busy
);

    localparam int K_W  = $clog2(`VIT_MLP_DIM);
    localparam int O_W  = $clog2(`VIT_HIDDEN_DIM);
    localparam int WA_W = `VIT_WADDR_W;

    q88_u w2 [`VIT_HIDDEN_DIM*`VIT_MLP_DIM];
    q88_u b2 [`VIT_HIDDEN_DIM];

    logic                         run;
    logic                         full_q;     // Previous full for start edge
    logic                         start_pend;
    logic [K_W:0]                 k_cnt;      // MLP_DIM means finish cycle
    logic [O_W-1:0]               o_cnt;
    logic                         finish;
    logic signed [`VIT_ACC_W-1:0] acc;
    logic signed [`VIT_ACC_W-1:0] prod;
    logic [WA_W-1:0]              w_idx;
    hid_vec_t                     stage;      // Outputs so far
    hid_vec_t                     stage_nxt;

    always_ff @(posedge clk) begin
        if (wload.en && wload.layer) begin
            if (wload.is_bias)
                b2[wload.addr[O_W-1:0]] <= wload.data;
            else
                w2[wload.addr] <= wload.data;
        end
    end

    assign start_pend = full && !full_q && !run;   // First full cycle
    assign busy       = run || start_pend;
    assign finish     = run && (k_cnt == `VIT_MLP_DIM);
    assign rd_idx     = k_cnt[K_W-1:0];
    assign w_idx      = WA_W'(o_cnt * `VIT_MLP_DIM) + WA_W'(k_cnt[K_W-1:0]);
    assign prod       = rd_data.raw * w2[w_idx].raw;

    always_comb begin
        stage_nxt            = stage;
        stage_nxt[o_cnt].raw = acc[`VIT_TRUNC_LSB +: `VIT_DATA_W] + b2[o_cnt].raw;
    end

    always_ff @(posedge clk) begin
        if (finish)
            stage <= stage_nxt;
    end

    //--------------------------------------
    // Output / input sequencing
    //--------------------------------------
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            run       <= 1'b0;
            full_q    <= 1'b0;
            k_cnt     <= '0;
            o_cnt     <= '0;
            acc       <= '0;
            y         <= '0;
            done      <= 1'b0;
            valid_out <= 1'b0;
        end else begin
            full_q    <= full;
            done      <= 1'b0;                     // Single-cycle pulses
            valid_out <= 1'b0;
            if (start_pend) begin
                run   <= 1'b1;
                k_cnt <= '0;
                o_cnt <= '0;
                acc   <= '0;
            end else if (finish) begin
                acc   <= '0;
                k_cnt <= '0;
                o_cnt <= o_cnt + 1'b1;
                if (o_cnt == O_W'(`VIT_HIDDEN_DIM-1)) begin
                    run       <= 1'b0;
                    y         <= stage_nxt;        // Includes last output
                    done      <= 1'b1;
                    valid_out <= 1'b1;
                end
            end else if (run) begin
                acc   <= acc + prod;
                k_cnt <= k_cnt + 1'b1;
            end
        end
    end

endmodule

/* source/act_buffer.sv */
//--------------------------------------
// Hidden activation store between the
// two layers. fc1 fills it by index,
// full tells fc2 to start, fc2 reads
// it back combinationally by index
//--------------------------------------
`timescale 1ns/100ps
`include "vit_mlp_consts.svh"

module act_buffer import vit_mlp_pkg::*; (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      clear,    // New patch, drop fill count
    input  act_wr_t                   act_wr,
    input  logic [`VIT_ACT_IDX_W-1:0] rd_idx,
    output q88_u                      rd_data,
    output logic                      full
);

    localparam int CNT_W = $clog2(`VIT_MLP_DIM + 1);

    q88_u             mem [`VIT_MLP_DIM];   // One word per hidden neuron
    logic [CNT_W-1:0] fill_cnt;

    // Payload
    always_ff @(posedge clk) begin
        if (act_wr.en)
            mem[act_wr.idx] <= act_wr.data;
    end

    // Fill count, clear wins
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            fill_cnt <= '0;
        end else if (clear) begin
            fill_cnt <= '0;
        end else if (act_wr.en) begin
            fill_cnt <= fill_cnt + 1'b1;
        end
    end

    assign full    = (fill_cnt == CNT_W'(`VIT_MLP_DIM));   // Eighth write landed
    assign rd_data = mem[rd_idx];

endmodule

/* source/fc1_gelu_stage.sv */
//--------------------------------------
// First linear layer plus GELU
// Captures x on launch, then for each
// hidden neuron runs HIDDEN_DIM MAC
// cycles and one finish cycle that
// writes the activation to the buffer
//--------------------------------------
`timescale 1ns/100ps
`include "vit_mlp_consts.svh"

module fc1_gelu_stage import vit_mlp_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     launch,     // Accept x, start neuron 0
    input  hid_vec_t x,
    input  wload_t   wload,
    output act_wr_t  act_wr,     // One write per neuron
    output logic     busy
);

    localparam int IN_W = $clog2(`VIT_HIDDEN_DIM);
    localparam int N_W  = $clog2(`VIT_MLP_DIM);
    localparam int WA_W = `VIT_WADDR_W;

    // Weight store, loaded from outside
    q88_u w1 [`VIT_MLP_DIM*`VIT_HIDDEN_DIM];
    q88_u b1 [`VIT_MLP_DIM];

    hid_vec_t                     x_r;       // Captured patch vector
    logic [IN_W:0]                in_cnt;    // HIDDEN_DIM means finish cycle
    logic [N_W-1:0]               n_cnt;     // Current neuron
    logic signed [`VIT_ACC_W-1:0] acc;
    logic signed [`VIT_ACC_W-1:0] prod;
    logic [WA_W-1:0]              w_idx;
    logic                         finish;
    q88_u                         pre_act;   // Truncated sum plus bias

    // Piecewise GELU, region picked from integer part
    function automatic q88_u gelu(input q88_u v);
        q88_u r;
        if (v.fx.ipart < -(`VIT_GELU_LIMIT)) begin
            r = '0;                                  // Far negative
        end else if (v.fx.ipart >= `VIT_GELU_LIMIT) begin
            r = v;                                   // Linear tail
        end else begin
            r.raw = (v.raw >>> 1) + `VIT_Q88_HALF;   // 0.5*v + 0.5
        end
        return r;
    endfunction

    //--------------------------------------
    // Weight and bias writes, layer 0
    //--------------------------------------
    always_ff @(posedge clk) begin
        if (wload.en && !wload.layer) begin
            if (wload.is_bias)
                b1[wload.addr[N_W-1:0]] <= wload.data;
            else
                w1[wload.addr] <= wload.data;
        end
    end

    always_ff @(posedge clk) begin
        if (launch)
            x_r <= x;
    end

    // Datapath
    assign finish = busy && (in_cnt == `VIT_HIDDEN_DIM);
    assign w_idx  = WA_W'(n_cnt * `VIT_HIDDEN_DIM) + WA_W'(in_cnt[IN_W-1:0]);
    assign prod   = x_r[in_cnt[IN_W-1:0]].raw * w1[w_idx].raw;

    always_comb begin
        pre_act.raw = acc[`VIT_TRUNC_LSB +: `VIT_DATA_W] + b1[n_cnt].raw;  // 16-bit wrap
        act_wr.en   = finish;
        act_wr.idx  = n_cnt;
        act_wr.data = gelu(pre_act);
    end

    //--------------------------------------
    // Neuron / input sequencing
    //--------------------------------------
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy   <= 1'b0;
            in_cnt <= '0;
            n_cnt  <= '0;
            acc    <= '0;
        end else if (launch) begin
            busy   <= 1'b1;
            in_cnt <= '0;
            n_cnt  <= '0;
            acc    <= '0;
        end else if (busy) begin
            if (finish) begin
                acc    <= '0;                        // Fresh sum for next neuron
                in_cnt <= '0;
                n_cnt  <= n_cnt + 1'b1;
                if (n_cnt == N_W'(`VIT_MLP_DIM-1))
                    busy <= 1'b0;                    // Last write this cycle
            end else begin
                acc    <= acc + prod;
                in_cnt <= in_cnt + 1'b1;
            end
        end
    end

endmodule

/* source/vit_mlp_pkg.sv */
//--------------------------------------
// Shared types of the ViT MLP block
// Q8.8 word, vector types and the packed
// port structs for weight load and the
// hidden-activation write port
//--------------------------------------
`include "vit_mlp_consts.svh"

package vit_mlp_pkg;

    // Integer / fraction split of a Q8.8 word
    typedef struct packed {
        logic signed [`VIT_DATA_W-`VIT_TRUNC_LSB-1:0] ipart;  // Floor of value
        logic        [`VIT_TRUNC_LSB-1:0]             fpart;
    } q88_fx_t;

    // One word, two readings
    typedef union packed {
        logic signed [`VIT_DATA_W-1:0] raw;   // Arithmetic view
        q88_fx_t                       fx;    // GELU region decode
    } q88_u;

    // Input and output vector, element 0 in the low bits
    typedef q88_u [`VIT_HIDDEN_DIM-1:0] hid_vec_t;

    //--------------------------------------
    // Port structs
    //--------------------------------------

    // Weight / bias write, only while idle
    typedef struct packed {
        logic                    en;
        logic                    layer;     // 0 fc1, 1 fc2
        logic                    is_bias;   // addr picks bias entry
        logic [`VIT_WADDR_W-1:0] addr;      // out * in_dim + in
        q88_u                    data;
    } wload_t;

    // fc1 to buffer write
    typedef struct packed {
        logic                      en;
        logic [`VIT_ACT_IDX_W-1:0] idx;     // Hidden neuron index
        q88_u                      data;    // Post GELU value
    } act_wr_t;

endpackage

/* include/vit_mlp_consts.svh */
//--------------------------------------
// Sizes, widths and Q8.8 constants for
// the ViT feed-forward block. Include in
// every file that needs a dimension
//--------------------------------------
`ifndef VIT_MLP_CONSTS_SVH
`define VIT_MLP_CONSTS_SVH

// Layer sizes
`define VIT_HIDDEN_DIM 4            // Input and output vector length
`define VIT_MLP_DIM    8            // Hidden layer length

// Word widths
`define VIT_DATA_W     16           // Q8.8 word
`define VIT_ACC_W      32           // Q16.16 accumulator
`define VIT_WADDR_W    5            // Weight load address
`define VIT_ACT_IDX_W  3            // Hidden buffer index

// Accumulator bit that becomes the Q8.8 LSB
`define VIT_TRUNC_LSB  8

// GELU region edges, integer part only
`define VIT_GELU_LIMIT 2
`define VIT_Q88_HALF   16'sh0080    // 0.5 in Q8.8

// Edge sampling start to edge seeing done
`define VIT_LATENCY    78

`endif
